/* source/qdr_pkg.sv */
`default_nettype none

// ==================================================
// shared widths and latencies for the qdr controller
// ==================================================
package qdr_pkg;

  // one beat on the data pins, a 36 bit word
  localparam int qdr_data_width_def = 36;

  // byte write lanes per beat, 9 bits each at the default width
  localparam int qdr_bw_width_def = 4;

  // sram address bits
  localparam int qdr_addr_width_def = 22;

  // read delay training knob width
  localparam int rn_dly_w = 5;

  // user strobe to command on the pins
  // one cycle in the issue stage, one in the pin stage
  localparam int issue_lat = 2;

  // qdr_q on the pins to the capture register
  localparam int capture_lat = 1;

endpackage

`default_nettype wire

/* source/qdr_reset_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_reset_seq #(
  parameter int STARTUP_CYCLES = 16
) (
  input  wire  clk0,
  input  wire  rst_n,
  input  wire  idelay_rdy,
  output logic ctl_rst_n,
  output logic phy_rdy,
  output logic qdr_dll_off_n
);

  // counter wide enough to hold the startup count
  localparam int cnt_w = $clog2(STARTUP_CYCLES + 1);

  logic [1:0]       rst_sync;
  logic [cnt_w-1:0] start_cnt;

  // ==================================================
  // reset release synchroniser
  // ==================================================
  // assert at once, release after two clk0 edges
  always_ff @(posedge clk0 or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign ctl_rst_n = rst_sync[1];

  // ==================================================
  // dll enable and startup wait
  // ==================================================
  always_ff @(posedge clk0 or negedge ctl_rst_n) begin
    if (!ctl_rst_n) begin
      qdr_dll_off_n <= 1'b0;
      start_cnt     <= '0;
      phy_rdy       <= 1'b0;
    end else begin
      // dll runs from the first edge after release
      qdr_dll_off_n <= 1'b1;
      if (!idelay_rdy) begin
        // delay elements lost lock, start over
        start_cnt <= '0;
        phy_rdy   <= 1'b0;
      end else if (start_cnt == cnt_w'(STARTUP_CYCLES - 1)) begin
        // hold the count, phy is up
        phy_rdy <= 1'b1;
      end else begin
        start_cnt <= start_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/qdr_wr.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_wr #(
  parameter int DATA_WIDTH = 36,
  parameter int BW_WIDTH   = 4
) (
  input  wire                      clk0,
  input  wire                      ctl_rst_n,
  input  wire                      phy_rdy,
  input  wire                      usr_wr_strb,
  input  wire [2*DATA_WIDTH-1:0]   usr_wr_data,
  input  wire [2*BW_WIDTH-1:0]     usr_wr_be,
  output logic                     wr_issue,
  output logic [DATA_WIDTH-1:0]    wr_d_rise,
  output logic [DATA_WIDTH-1:0]    wr_d_fall,
  output logic [BW_WIDTH-1:0]      wr_bw_n_rise,
  output logic [BW_WIDTH-1:0]      wr_bw_n_fall
);

  // write accepted this cycle
  logic wr_go;

  // strobes before the phy is up are dropped
  assign wr_go = usr_wr_strb & phy_rdy;

  // ==================================================
  // command and byte write lanes
  // ==================================================
  always_ff @(posedge clk0 or negedge ctl_rst_n) begin
    if (!ctl_rst_n) begin
      wr_issue     <= 1'b0;
      wr_bw_n_rise <= '1;
      wr_bw_n_fall <= '1;
    end else begin
      wr_issue <= wr_go;
      if (wr_go) begin
        // active high enables become active low bw_n
        wr_bw_n_rise <= ~usr_wr_be[BW_WIDTH-1:0];
        wr_bw_n_fall <= ~usr_wr_be[2*BW_WIDTH-1:BW_WIDTH];
      end else begin
        // idle, no lane written
        wr_bw_n_rise <= '1;
        wr_bw_n_fall <= '1;
      end
    end
  end

  // ==================================================
  // write data beats
  // ==================================================
  // rise beat in the low half, fall beat in the high half
  always_ff @(posedge clk0) begin
    if (wr_go) begin
      wr_d_rise <= usr_wr_data[DATA_WIDTH-1:0];
      wr_d_fall <= usr_wr_data[2*DATA_WIDTH-1:DATA_WIDTH];
    end
  end

  // data holds between writes, bw_n keeps the sram idle

endmodule

`default_nettype wire

/* source/qdr_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_rd #(
  parameter int DATA_WIDTH = 36
) (
  input  wire                          clk0,
  input  wire                          ctl_rst_n,
  input  wire                          phy_rdy,
  input  wire [qdr_pkg::rn_dly_w-1:0]  rn_dly,
  input  wire                          usr_rd_strb,
  output logic                         rd_issue,
  input  wire [DATA_WIDTH-1:0]         q_rise,
  input  wire [DATA_WIDTH-1:0]         q_fall,
  output logic [2*DATA_WIDTH-1:0]      usr_rd_data,
  output logic                         usr_rd_dvld
);

  import qdr_pkg::*;

  // ==================================================
  // delay line geometry
  // ==================================================
  // line bit 0 is the issue register, bit k is k cycles later
  // with rn_dly of 0 the data comes issue_lat + capture_lat
  // cycles after the strobe, which is tap 1 here
  localparam int tap_base = issue_lat + capture_lat - 2;

  // room for every rn_dly setting
  localparam int line_len = tap_base + (2 ** rn_dly_w);

  // tap index needs one bit more than rn_dly
  localparam int tap_w = rn_dly_w + 1;

  logic                rd_go;
  logic [line_len-1:0] rd_line;
  logic [tap_w-1:0]    tap_idx;
  logic                tap_hit;

  // ==================================================
  // read issue
  // ==================================================
  // drop reads until the phy is ready
  assign rd_go = usr_rd_strb & phy_rdy;

  // the shift register holds one bit per read in flight,
  // so back to back reads need no counter
  always_ff @(posedge clk0 or negedge ctl_rst_n) begin
    if (!ctl_rst_n) begin
      rd_line <= '0;
    end else begin
      rd_line <= {rd_line[line_len-2:0], rd_go};
    end
  end

  // first stage goes straight to the pin stage
  assign rd_issue = rd_line[0];

  // ==================================================
  // programmable tap
  // ==================================================
  // rn_dly trains the strobe onto the returning data
  assign tap_idx = tap_w'(rn_dly) + tap_w'(tap_base);
  assign tap_hit = rd_line[tap_idx];

  // valid pulse, one per issued read
  always_ff @(posedge clk0 or negedge ctl_rst_n) begin
    if (!ctl_rst_n) begin
      usr_rd_dvld <= 1'b0;
    end else begin
      usr_rd_dvld <= tap_hit;
    end
  end

  // ==================================================
  // read data
  // ==================================================
  // fall beat in the high half, same packing as the write side
  always_ff @(posedge clk0) begin
    if (tap_hit) begin
      usr_rd_data <= {q_fall, q_rise};
    end
  end

  // data holds until the next valid read,
  // only sampled while usr_rd_dvld is high

endmodule

`default_nettype wire

/* source/qdr_phy.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_phy #(
  parameter int DATA_WIDTH = 36,
  parameter int BW_WIDTH   = 4,
  parameter int ADDR_WIDTH = 22
) (
  input  wire                     clk0,
  input  wire                     ctl_rst_n,
  input  wire  [ADDR_WIDTH-1:0]   usr_addr,
  input  wire                     wr_issue,
  input  wire  [DATA_WIDTH-1:0]   wr_d_rise,
  input  wire  [DATA_WIDTH-1:0]   wr_d_fall,
  input  wire  [BW_WIDTH-1:0]     wr_bw_n_rise,
  input  wire  [BW_WIDTH-1:0]     wr_bw_n_fall,
  input  wire                     rd_issue,
  output logic [DATA_WIDTH-1:0]   q_rise,
  output logic [DATA_WIDTH-1:0]   q_fall,
  output logic [ADDR_WIDTH-1:0]   qdr_sa,
  output logic                    qdr_w_n,
  output logic                    qdr_r_n,
  output logic [DATA_WIDTH-1:0]   qdr_d_rise,
  output logic [DATA_WIDTH-1:0]   qdr_d_fall,
  output logic [BW_WIDTH-1:0]     qdr_bw_n_rise,
  output logic [BW_WIDTH-1:0]     qdr_bw_n_fall,
  input  wire  [DATA_WIDTH-1:0]   qdr_q_rise,
  input  wire  [DATA_WIDTH-1:0]   qdr_q_fall
);

  import qdr_pkg::*;

  logic [ADDR_WIDTH-1:0] sa_pipe [issue_lat];
  logic [DATA_WIDTH-1:0] qr_pipe [capture_lat];
  logic [DATA_WIDTH-1:0] qf_pipe [capture_lat];

  // ==================================================
  // address pipe
  // ==================================================
  // address comes with the user strobe, the command
  // takes issue_lat cycles to reach the pins
  always_ff @(posedge clk0) begin
    sa_pipe[0] <= usr_addr;
    for (int i = 1; i < issue_lat; i++) begin
      sa_pipe[i] <= sa_pipe[i-1];
    end
  end

  // last stage is the pin register
  assign qdr_sa = sa_pipe[issue_lat-1];

  // ==================================================
  // command, data and byte write pins
  // ==================================================
  always_ff @(posedge clk0 or negedge ctl_rst_n) begin
    if (!ctl_rst_n) begin
      qdr_w_n       <= 1'b1;
      qdr_r_n       <= 1'b1;
      qdr_bw_n_rise <= '1;
      qdr_bw_n_fall <= '1;
    end else begin
      // ports are active low on the sram
      qdr_w_n       <= ~wr_issue;
      qdr_r_n       <= ~rd_issue;
      qdr_bw_n_rise <= wr_bw_n_rise;
      qdr_bw_n_fall <= wr_bw_n_fall;
    end
  end

  always_ff @(posedge clk0) begin
    qdr_d_rise <= wr_d_rise;
    qdr_d_fall <= wr_d_fall;
  end

  // ==================================================
  // read capture
  // ==================================================
  always_ff @(posedge clk0) begin
    qr_pipe[0] <= qdr_q_rise;
    qf_pipe[0] <= qdr_q_fall;
    for (int i = 1; i < capture_lat; i++) begin
      qr_pipe[i] <= qr_pipe[i-1];
      qf_pipe[i] <= qf_pipe[i-1];
    end
  end

  assign q_rise = qr_pipe[capture_lat-1];
  assign q_fall = qf_pipe[capture_lat-1];

endmodule

`default_nettype wire

/* source/qdr_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_controller #(
  parameter int DATA_WIDTH     = qdr_pkg::qdr_data_width_def,
  parameter int BW_WIDTH       = qdr_pkg::qdr_bw_width_def,
  parameter int ADDR_WIDTH     = qdr_pkg::qdr_addr_width_def,
  parameter int STARTUP_CYCLES = 16
) (
  input  wire                          clk0,
  input  wire                          rst_n,
  input  wire                          idelay_rdy,
  // user side
  input  wire                          usr_rd_strb,
  input  wire                          usr_wr_strb,
  input  wire [ADDR_WIDTH-1:0]         usr_addr,
  input  wire [2*DATA_WIDTH-1:0]       usr_wr_data,
  input  wire [2*BW_WIDTH-1:0]         usr_wr_be,
  input  wire [qdr_pkg::rn_dly_w-1:0]  rn_dly,
  output logic [2*DATA_WIDTH-1:0]      usr_rd_data,
  output logic                         usr_rd_dvld,
  output logic                         phy_rdy,
  // sram pins
  output logic [ADDR_WIDTH-1:0]        qdr_sa,
  output logic                         qdr_w_n,
  output logic                         qdr_r_n,
  output logic                         qdr_dll_off_n,
  output logic [DATA_WIDTH-1:0]        qdr_d_rise,
  output logic [DATA_WIDTH-1:0]        qdr_d_fall,
  output logic [BW_WIDTH-1:0]          qdr_bw_n_rise,
  output logic [BW_WIDTH-1:0]          qdr_bw_n_fall,
  input  wire [DATA_WIDTH-1:0]         qdr_q_rise,
  input  wire [DATA_WIDTH-1:0]         qdr_q_fall
);

  logic                  ctl_rst_n;
  // write stage to pin stage
  logic                  wr_issue;
  logic [DATA_WIDTH-1:0] wr_d_rise;
  logic [DATA_WIDTH-1:0] wr_d_fall;
  logic [BW_WIDTH-1:0]   wr_bw_n_rise;
  logic [BW_WIDTH-1:0]   wr_bw_n_fall;
  // read stage and pin stage
  logic                  rd_issue;
  logic [DATA_WIDTH-1:0] q_rise;
  logic [DATA_WIDTH-1:0] q_fall;

  // ==================================================
  // reset and startup
  // ==================================================
  qdr_reset_seq #(.STARTUP_CYCLES(STARTUP_CYCLES)) reset_seq0 (
    .clk0(clk0), .rst_n(rst_n), .idelay_rdy(idelay_rdy),
    .ctl_rst_n(ctl_rst_n), .phy_rdy(phy_rdy), .qdr_dll_off_n(qdr_dll_off_n)
  );

  // ==================================================
  // issue stages
  // ==================================================
  qdr_wr #(.DATA_WIDTH(DATA_WIDTH), .BW_WIDTH(BW_WIDTH)) wr0 (
    .clk0(clk0), .ctl_rst_n(ctl_rst_n), .phy_rdy(phy_rdy),
    .usr_wr_strb(usr_wr_strb), .usr_wr_data(usr_wr_data), .usr_wr_be(usr_wr_be),
    .wr_issue(wr_issue), .wr_d_rise(wr_d_rise), .wr_d_fall(wr_d_fall),
    .wr_bw_n_rise(wr_bw_n_rise), .wr_bw_n_fall(wr_bw_n_fall)
  );

  // read issue plus realignment of the returned data
  qdr_rd #(.DATA_WIDTH(DATA_WIDTH)) rd0 (
    .clk0(clk0), .ctl_rst_n(ctl_rst_n), .phy_rdy(phy_rdy), .rn_dly(rn_dly),
    .usr_rd_strb(usr_rd_strb), .rd_issue(rd_issue), .q_rise(q_rise), .q_fall(q_fall),
    .usr_rd_data(usr_rd_data), .usr_rd_dvld(usr_rd_dvld)
  );

  // ==================================================
  // pin stage
  // ==================================================
  qdr_phy #(.DATA_WIDTH(DATA_WIDTH), .BW_WIDTH(BW_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) phy0 (
    .clk0(clk0), .ctl_rst_n(ctl_rst_n), .usr_addr(usr_addr),
    .wr_issue(wr_issue), .wr_d_rise(wr_d_rise), .wr_d_fall(wr_d_fall),
    .wr_bw_n_rise(wr_bw_n_rise), .wr_bw_n_fall(wr_bw_n_fall),
    .rd_issue(rd_issue), .q_rise(q_rise), .q_fall(q_fall),
    .qdr_sa(qdr_sa), .qdr_w_n(qdr_w_n), .qdr_r_n(qdr_r_n),
    .qdr_d_rise(qdr_d_rise), .qdr_d_fall(qdr_d_fall),
    .qdr_bw_n_rise(qdr_bw_n_rise), .qdr_bw_n_fall(qdr_bw_n_fall),
    .qdr_q_rise(qdr_q_rise), .qdr_q_fall(qdr_q_fall)
  );

endmodule

`default_nettype wire

/* tests/qdr_sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_sram_model #(
  parameter int DATA_WIDTH = 36,
  parameter int BW_WIDTH   = 4,
  parameter int ADDR_WIDTH = 6,
  parameter int LATENCY    = 2
) (
  input  wire                   clk0,
  input  wire  [ADDR_WIDTH-1:0] sa,
  input  wire                   w_n,
  input  wire                   r_n,
  input  wire  [DATA_WIDTH-1:0] d_rise,
  input  wire  [DATA_WIDTH-1:0] d_fall,
  input  wire  [BW_WIDTH-1:0]   bw_n_rise,
  input  wire  [BW_WIDTH-1:0]   bw_n_fall,
  output logic [DATA_WIDTH-1:0] q_rise,
  output logic [DATA_WIDTH-1:0] q_fall
);

  localparam int lane_w = DATA_WIDTH / BW_WIDTH;
  localparam int depth  = 2 ** ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem_rise [depth];
  logic [DATA_WIDTH-1:0] mem_fall [depth];
  // read pipe, last stage drives q
  logic [DATA_WIDTH-1:0] qr_pipe [LATENCY];
  logic [DATA_WIDTH-1:0] qf_pipe [LATENCY];

  // power up contents, a function of the whole address
  initial begin
    for (int a = 0; a < depth; a++) begin
      mem_rise[a] = DATA_WIDTH'(a * 32'h0101_0101 + 32'h00a5_5a00);
      mem_fall[a] = ~mem_rise[a];
    end
  end

  // ==================================================
  // read pipe and byte writes
  // ==================================================
  // all updates are nonblocking, so a read sees the array
  // from before a write in the same cycle
  always @(posedge clk0) begin
    if (r_n === 1'b0) begin
      qr_pipe[0] <= mem_rise[sa];
      qf_pipe[0] <= mem_fall[sa];
    end
    for (int i = 1; i < LATENCY; i++) begin
      qr_pipe[i] <= qr_pipe[i-1];
      qf_pipe[i] <= qf_pipe[i-1];
    end
    // bw_n low enables one lane of one beat
    if (w_n === 1'b0) begin
      for (int l = 0; l < BW_WIDTH; l++) begin
        if (!bw_n_rise[l]) begin
          mem_rise[sa][l*lane_w +: lane_w] <= d_rise[l*lane_w +: lane_w];
        end
        if (!bw_n_fall[l]) begin
          mem_fall[sa][l*lane_w +: lane_w] <= d_fall[l*lane_w +: lane_w];
        end
      end
    end
  end

  // q holds the last read until the next one
  assign q_rise = qr_pipe[LATENCY-1];
  assign q_fall = qf_pipe[LATENCY-1];

endmodule

`default_nettype wire

/* tests/qdr_controller_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_controller_tb;

  import qdr_pkg::*;

  localparam int dw             = qdr_data_width_def;
  localparam int bw             = qdr_bw_width_def;
  localparam int aw             = 6;
  localparam int startup_cycles = 16;
  localparam int lane_w         = dw / bw;

  logic                clk0;
  logic                rst_n;
  logic                idelay_rdy;
  logic                usr_rd_strb;
  logic                usr_wr_strb;
  logic [aw-1:0]       usr_addr;
  logic [2*dw-1:0]     usr_wr_data;
  logic [2*bw-1:0]     usr_wr_be;
  logic [rn_dly_w-1:0] rn_dly;
  wire  [2*dw-1:0]     usr_rd_data;
  wire                 usr_rd_dvld;
  wire                 phy_rdy;
  wire  [aw-1:0]       qdr_sa;
  wire                 qdr_w_n;
  wire                 qdr_r_n;
  wire                 qdr_dll_off_n;
  wire  [dw-1:0]       qdr_d_rise;
  wire  [dw-1:0]       qdr_d_fall;
  wire  [bw-1:0]       qdr_bw_n_rise;
  wire  [bw-1:0]       qdr_bw_n_fall;
  wire  [dw-1:0]       qdr_q_rise;
  wire  [dw-1:0]       qdr_q_fall;

  integer          seed = 32'h52f6_5c98;
  int              cyc = 0;
  int              got_lat;
  bit              chk_data = 1'b1;
  logic [2*dw-1:0] want;
  logic [2*dw-1:0] ref_mem [2**aw];
  // one entry per read in flight with the oldest first
  logic [2*dw-1:0] exp_data [$];
  int              exp_cyc [$];
  int              exp_lat [$];
  bit              exp_chk [$];

  qdr_controller #(.ADDR_WIDTH(aw), .STARTUP_CYCLES(startup_cycles)) dut0 (
    .clk0(clk0), .rst_n(rst_n), .idelay_rdy(idelay_rdy),
    .usr_rd_strb(usr_rd_strb), .usr_wr_strb(usr_wr_strb), .usr_addr(usr_addr),
    .usr_wr_data(usr_wr_data), .usr_wr_be(usr_wr_be), .rn_dly(rn_dly),
    .usr_rd_data(usr_rd_data), .usr_rd_dvld(usr_rd_dvld), .phy_rdy(phy_rdy),
    .qdr_sa(qdr_sa), .qdr_w_n(qdr_w_n), .qdr_r_n(qdr_r_n), .qdr_dll_off_n(qdr_dll_off_n),
    .qdr_d_rise(qdr_d_rise), .qdr_d_fall(qdr_d_fall),
    .qdr_bw_n_rise(qdr_bw_n_rise), .qdr_bw_n_fall(qdr_bw_n_fall),
    .qdr_q_rise(qdr_q_rise), .qdr_q_fall(qdr_q_fall)
  );

  qdr_sram_model #(.DATA_WIDTH(dw), .BW_WIDTH(bw), .ADDR_WIDTH(aw), .LATENCY(2)) sram0 (
    .clk0(clk0), .sa(qdr_sa), .w_n(qdr_w_n), .r_n(qdr_r_n),
    .d_rise(qdr_d_rise), .d_fall(qdr_d_fall),
    .bw_n_rise(qdr_bw_n_rise), .bw_n_fall(qdr_bw_n_fall),
    .q_rise(qdr_q_rise), .q_fall(qdr_q_fall)
  );

  initial begin
    clk0 = 1'b0;
    forever #50 clk0 = ~clk0;
  end

  // edge count that reads back as the old value on the same edge
  always @(posedge clk0) begin
    cyc <= cyc + 1;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [2*dw-1:0] got,
                             input logic [2*dw-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("** Error: %s is %h, expected %h", name, got, exp));
    end
  endtask

  // expected word after a write where lane i follows be[i]
  function automatic logic [2*dw-1:0] merge_write(input logic [2*dw-1:0] old_word,
                                                  input logic [2*dw-1:0] new_word,
                                                  input logic [2*bw-1:0] be);
    logic [2*dw-1:0] res;
    res = old_word;
    for (int i = 0; i < 2*bw; i++) begin
      if (be[i]) begin
        res[i*lane_w +: lane_w] = new_word[i*lane_w +: lane_w];
      end
    end
    return res;
  endfunction

  function automatic logic [2*dw-1:0] rand_word();
    logic [95:0] r;
    r = {$random(seed), $random(seed), $random(seed)};
    return r[2*dw-1:0];
  endfunction

  function automatic logic [aw-1:0] rand_addr();
    logic [31:0] r;
    r = $random(seed);
    return r[aw-1:0];
  endfunction

  // one clock of user strobes where reads queue what the reference holds
  task automatic drive_cycle(input bit rd, input bit wr, input logic [aw-1:0] addr,
                             input logic [2*dw-1:0] data, input logic [2*bw-1:0] be);
    @(posedge clk0);
    usr_rd_strb <= rd;
    usr_wr_strb <= wr;
    usr_addr    <= addr;
    usr_wr_data <= data;
    usr_wr_be   <= be;
    // read goes first so a same cycle write is not seen
    if (rd) begin
      exp_data.push_back(ref_mem[addr]);
      exp_cyc.push_back(cyc + 1);
      exp_lat.push_back(3 + int'(rn_dly));
      exp_chk.push_back(chk_data);
    end
    if (wr) begin
      ref_mem[addr] = merge_write(ref_mem[addr], data, be);
    end
  endtask

  task automatic wait_reads_done();
    int n;
    n = 0;
    drive_cycle(1'b0, 1'b0, '0, '0, '0);
    while (exp_data.size() != 0) begin
      @(posedge clk0);
      n = n + 1;
      if (n > 64) begin
        stop_on_error("timeout waiting for usr_rd_dvld, reads still outstanding");
      end
    end
  endtask

  // ==================================================
  // read return compare
  // ==================================================
  always @(negedge clk0) begin
    if (usr_rd_dvld === 1'b1) begin
      if (exp_data.size() == 0) begin
        stop_on_error("usr_rd_dvld pulsed with no read in flight");
      end else begin
        got_lat = cyc - exp_cyc.pop_front();
        want = exp_data.pop_front();
        check_value("usr_rd_dvld latency", got_lat, exp_lat.pop_front());
        if (exp_chk.pop_front()) begin
          check_value("usr_rd_data", usr_rd_data, want);
        end
      end
    end
  end

  initial begin
    int              n;
    logic [aw-1:0]   addr_list [16];
    logic [aw-1:0]   a;
    logic [2*dw-1:0] w;
    logic [2*bw-1:0] be;
    rst_n       = 1'b0;
    idelay_rdy  = 1'b1;
    usr_rd_strb = 1'b0;
    usr_wr_strb = 1'b0;
    usr_addr    = '0;
    usr_wr_data = '0;
    usr_wr_be   = '0;
    rn_dly      = rn_dly_w'(3);
    repeat (3) @(posedge clk0);
    rst_n <= 1'b1;

    // ==================================================
    // reset values, startup wait, dropped strobes
    // ==================================================
    @(negedge clk0);
    check_value("qdr_dll_off_n", qdr_dll_off_n, 1'b0);
    check_value("phy_rdy", phy_rdy, 1'b0);
    check_value("qdr_bw_n_rise", qdr_bw_n_rise, {bw{1'b1}});
    n = 0;
    while (phy_rdy !== 1'b1) begin
      @(posedge clk0);
      n = n + 1;
      if (n > startup_cycles + 8) begin
        stop_on_error("timeout waiting for phy_rdy after reset release");
      end
      // phy still down so these never reach the pins
      usr_rd_strb <= (n <= 4);
      usr_wr_strb <= (n <= 4);
      usr_addr    <= rand_addr();
      usr_wr_data <= rand_word();
      usr_wr_be   <= '1;
      @(negedge clk0);
      check_value("qdr_w_n", qdr_w_n, 1'b1);
      check_value("qdr_r_n", qdr_r_n, 1'b1);
      check_value("usr_rd_dvld", usr_rd_dvld, 1'b0);
    end
    if (n < startup_cycles) begin
      stop_on_error($sformatf("phy_rdy rose only %0d cycles after reset release", n));
    end
    // dll enabled once reset has released
    check_value("qdr_dll_off_n", qdr_dll_off_n, 1'b1);

    // ==================================================
    // preload, pin timing, full and partial writes
    // ==================================================
    for (int i = 0; i < 2**aw; i++) begin
      drive_cycle(1'b0, 1'b1, aw'(i), rand_word(), '1);
    end
    // read plus write on one address reaches the pins two edges on
    a = rand_addr();
    w = rand_word();
    drive_cycle(1'b1, 1'b1, a, w, '1);
    drive_cycle(1'b0, 1'b0, '0, '0, '0);
    drive_cycle(1'b0, 1'b0, '0, '0, '0);
    @(negedge clk0);
    check_value("qdr_w_n", qdr_w_n, 1'b0);
    check_value("qdr_r_n", qdr_r_n, 1'b0);
    check_value("qdr_sa", qdr_sa, a);
    check_value("qdr_d_rise", qdr_d_rise, w[dw-1:0]);
    check_value("qdr_d_fall", qdr_d_fall, w[2*dw-1:dw]);
    check_value("qdr_bw_n_rise", qdr_bw_n_rise, '0);
    check_value("qdr_bw_n_fall", qdr_bw_n_fall, '0);
    // pass 0 with full enables and pass 1 with random lanes
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 16; i++) begin
        addr_list[i] = rand_addr();
        w = rand_word();
        be = (p == 0) ? {2*bw{1'b1}} : w[2*bw-1:0];
        drive_cycle(1'b0, 1'b1, addr_list[i], rand_word(), be);
      end
      for (int i = 0; i < 16; i++) begin
        drive_cycle(1'b1, 1'b0, addr_list[i], '0, '0);
      end
      wait_reads_done();
    end

    // ==================================================
    // back to back reads with writes mixed in
    // ==================================================
    // small address range so reads hit recent writes
    for (int i = 0; i < 48; i++) begin
      a = rand_addr() & aw'(7);
      w = rand_word();
      drive_cycle(1'b1, w[2*dw-1], a, rand_word(), w[2*bw-1:0]);
    end
    wait_reads_done();

    // retrained delay where only the latency is checked
    @(posedge clk0);
    rn_dly <= rn_dly_w'(5);
    chk_data = 1'b0;
    for (int i = 0; i < 8; i++) begin
      drive_cycle(i % 3 != 2, 1'b0, rand_addr(), '0, '0);
    end
    wait_reads_done();
    repeat (10) @(posedge clk0);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* qdr_controller.f */
source/qdr_pkg.sv
source/qdr_reset_seq.sv
source/qdr_wr.sv
source/qdr_rd.sv
source/qdr_phy.sv
source/qdr_controller.sv
tests/qdr_sram_model.sv
tests/qdr_controller_tb.sv
